// ==== files.f ====
hdl/cachePkg.sv
hdl/cacheSram.sv
hdl/sramArbiter.sv
hdl/pageController.sv
hdl/cacheManagement.sv
hdl/flashCache.sv
verif/flashCacheTb.sv

// ==== run.sh ====
#!/bin/sh
# Builds and runs the flash cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing -Wno-fatal -f files.f --top-module flashCacheTb \
	-o flashCacheSim > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/flashCacheSim > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
	echo "Simulation exited with status $simStatus"
	exit 1
fi

if grep -q "^Verification passed$" sim.log; then
	exit 0
fi
echo "Pass message not found in sim.log"
exit 1

// ==== verif/flashCacheTb.sv ====
`timescale 1ns/1ns
`default_nettype none

module flashCacheTb;

	localparam int halfPeriod = 20;
	localparam int sramWords = 1 << cachePkg::sramAddressSize;
	localparam int accessTimeout = 100;
	localparam int fillTimeout = 20000;
	localparam int pollLimit = 5000;

	logic clk;
	logic rst;
	logic we;
	logic oe;
	logic [23:0] address;
	logic [3:0] byteSelect;
	logic [31:0] dataWrite;
	wire [31:0] dataRead;
	wire busy;
	wire memEnable;
	wire [23:0] memAddress;
	logic [31:0] memDataRead;
	logic memBusy;

	integer seed;
	integer errorCount;
	integer checkCount;
	integer memWait;
	logic memActive;

	// Reference model state
	logic [2:0] configModel;
	logic [31:0] sramModel [0:sramWords-1];
	logic [31:0] backing [int];

	flashCache uut (
		.clk(clk),
		.rst(rst),
		.we(we),
		.oe(oe),
		.address(address),
		.byteSelect(byteSelect),
		.dataWrite(dataWrite),
		.dataRead(dataRead),
		.busy(busy),
		.memEnable(memEnable),
		.memAddress(memAddress),
		.memDataRead(memDataRead),
		.memBusy(memBusy)
	);

	initial begin
		clk = 1'b0;
		forever #halfPeriod clk = ~clk;
	end

	// Backing memory answers each request after 0 to 3 busy cycles
	always @(negedge clk) begin
		if (memEnable !== 1'b1) begin
			memActive = 1'b0;
			memBusy = 1'b1;
		end else begin
			if (!memActive) begin
				memActive = 1'b1;
				memWait = $random(seed) & 3;
			end else if (memWait > 0) begin
				memWait = memWait - 1;
			end
			memBusy = memWait != 0;
			if (memWait == 0) begin
				if (backing.exists(int'(memAddress[23:2]))) begin
					memDataRead = backing[int'(memAddress[23:2])];
				end else begin
					errorCount++;
					$display("Backing memory read at %h falls outside the loaded region",
						memAddress);
					memDataRead = '0;
				end
			end
		end
	end

	function automatic logic [23:0] registerAddress(input logic [11:0] offset);
		return {cachePkg::registerBase, offset};
	endfunction

	function automatic logic [23:0] windowAddress(input logic [8:0] word);
		return {13'b0, word, 2'b00};
	endfunction

	function automatic logic [31:0] mergeLanes(input logic [31:0] old, input logic [31:0] data,
			input logic [3:0] sel);
		logic [31:0] merged;
		int lane;
		merged = old;
		for (lane = 0; lane < 4; lane++) begin
			if (sel[lane]) begin
				merged[lane*8 +: 8] = data[lane*8 +: 8];
			end
		end
		return merged;
	endfunction

	task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
			input string what);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("Fail at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
		end
	endtask

	// Holds the access until busy is low ahead of a rising edge
	task automatic busAccess(input logic write, input logic [23:0] addr, input logic [3:0] sel,
			input logic [31:0] data, input int limit, output logic [31:0] result,
			output int waited);
		@(negedge clk);
		we = write;
		oe = !write;
		address = addr;
		byteSelect = sel;
		dataWrite = data;
		waited = 0;
		#(halfPeriod / 2);
		while (busy && waited < limit) begin
			@(negedge clk);
			#(halfPeriod / 2);
			waited++;
		end
		result = dataRead;
		if (busy) begin
			errorCount++;
			$display("Timeout: access to address %h still busy after %0d cycles", addr, limit);
		end
		@(posedge clk);
		@(negedge clk);
		we = 1'b0;
		oe = 1'b0;
	endtask

	task automatic writeBus(input logic [23:0] addr, input logic [3:0] sel,
			input logic [31:0] data);
		logic [31:0] result;
		int waited;
		busAccess(1'b1, addr, sel, data, accessTimeout, result, waited);
	endtask

	task automatic readCheck(input logic [23:0] addr, input logic [31:0] expected,
			input string what);
		logic [31:0] result;
		int waited;
		busAccess(1'b0, addr, 4'hF, '0, accessTimeout, result, waited);
		checkValue(result, expected, what);
	endtask

	task automatic exerciseWindow(input int count, input logic writesLand);
		logic [31:0] data;
		logic [31:0] result;
		logic [3:0] sel;
		logic [8:0] word;
		int waited;
		repeat (count) begin
			word = 9'($random(seed));
			data = $random(seed);
			sel = 4'($random(seed));
			if ($random(seed) & 1) begin
				writeBus(windowAddress(word), sel, data);
				if (writesLand) begin
					sramModel[word] = mergeLanes(sramModel[word], data, sel);
				end
			end else begin
				busAccess(1'b0, windowAddress(word), 4'hF, '0, accessTimeout, result, waited);
				checkValue(result, sramModel[word], "SRAM window word");
				checkValue(32'(waited), 32'd1, "SRAM read wait cycles");
			end
		end
	endtask

	task automatic loadRegion(input logic [12:0] region);
		logic [8:0] word;
		word = '0;
		repeat (sramWords) begin
			backing[int'({region, word})] = $random(seed);
			word++;
		end
	endtask

	task automatic startFill(input logic [12:0] region);
		logic [31:0] data;
		loadRegion(region);
		// Junk outside bits 23 to 11 must not reach the region
		data = $random(seed);
		data[23:11] = region;
		writeBus(registerAddress(cachePkg::pageAddressOffset), 4'hF, data);
	endtask

	task automatic waitForLoading(input logic level);
		logic [31:0] result;
		int waited;
		int polls;
		polls = 0;
		result = {30'b0, !level, 1'b0};
		while (result[1] !== level && polls < pollLimit) begin
			busAccess(1'b0, registerAddress(cachePkg::statusOffset), 4'hF, '0, accessTimeout,
				result, waited);
			polls++;
		end
		if (result[1] !== level) begin
			errorCount++;
			$display("Timeout: status loading bit never became %0d", level);
		end
	endtask

	task automatic checkAllWords(input logic [12:0] region);
		logic [31:0] result;
		logic [8:0] word;
		int waited;
		word = '0;
		repeat (sramWords) begin
			sramModel[word] = backing[int'({region, word})];
			busAccess(1'b0, windowAddress(word), 4'hF, '0, accessTimeout, result, waited);
			checkValue(result, sramModel[word], "SRAM word after fill");
			checkValue(32'(waited), 32'd1, "SRAM read wait cycles");
			word++;
		end
	endtask

	initial begin
		logic [31:0] result;
		logic [31:0] data;
		logic [3:0] sel;
		logic [8:0] word;
		logic [23:0] addr;
		logic [12:0] region;
		int waited;

		seed = 99;
		errorCount = 0;
		checkCount = 0;
		rst = 1'b1;
		we = 1'b0;
		oe = 1'b0;
		address = '0;
		byteSelect = '0;
		dataWrite = '0;
		memDataRead = '0;
		memBusy = 1'b1;
		memActive = 1'b0;
		memWait = 0;
		configModel = '0;
		repeat (5) @(negedge clk);
		rst = 1'b0;

		readCheck(registerAddress(cachePkg::configOffset), 32'h0, "configuration after reset");
		readCheck(registerAddress(cachePkg::statusOffset), 32'h0, "status after reset");
		readCheck(registerAddress(cachePkg::pageAddressOffset), 32'h0, "page address after reset");
		readCheck(registerAddress(cachePkg::cacheStatusOffset), 32'h0, "cache status after reset");

		// Configuration lives in byte lane 0
		repeat (40) begin
			data = $random(seed);
			sel = 4'($random(seed));
			writeBus(registerAddress(cachePkg::configOffset), sel, data);
			if (sel[0]) begin
				configModel = data[2:0];
			end
			readCheck(registerAddress(cachePkg::configOffset), {29'b0, configModel},
				"configuration");
		end

		configModel = 3'b100;
		writeBus(registerAddress(cachePkg::configOffset), 4'h1, 32'h4);
		readCheck(registerAddress(cachePkg::configOffset), {29'b0, configModel},
			"configuration");
		word = '0;
		repeat (sramWords) begin
			data = $random(seed);
			writeBus(windowAddress(word), 4'hF, data);
			sramModel[word] = data;
			word++;
		end
		exerciseWindow(300, 1'b1);
		configModel = 3'b000;
		writeBus(registerAddress(cachePkg::configOffset), 4'h1, 32'h0);
		readCheck(registerAddress(cachePkg::configOffset), {29'b0, configModel},
			"configuration");
		exerciseWindow(100, 1'b0);

		// Disabled cache stores the region without filling
		region = 13'($random(seed));
		writeBus(registerAddress(cachePkg::pageAddressOffset), 4'hF, {8'h0, region, 11'h0});
		readCheck(registerAddress(cachePkg::statusOffset), 32'h0, "status with cache disabled");
		readCheck(registerAddress(cachePkg::cacheStatusOffset), 32'h0,
			"cache status with cache disabled");
		readCheck(registerAddress(cachePkg::pageAddressOffset), {8'h0, region, 11'h0},
			"page address with cache disabled");

		configModel = 3'b101;
		writeBus(registerAddress(cachePkg::configOffset), 4'h1, 32'h5);
		readCheck(registerAddress(cachePkg::configOffset), {29'b0, configModel},
			"configuration");
		region = 13'($random(seed));
		startFill(region);
		waitForLoading(1'b1);
		waitForLoading(1'b0);
		readCheck(registerAddress(cachePkg::cacheStatusOffset), 32'h0000_00FF,
			"cache status after fill");
		readCheck(registerAddress(cachePkg::statusOffset), 32'h1, "status after fill");
		readCheck(registerAddress(cachePkg::pageAddressOffset), {8'h0, region, 11'h0},
			"page address after fill");
		checkAllWords(region);

		// Window read issued while the second fill runs
		region = 13'($random(seed));
		startFill(region);
		word = 9'($random(seed));
		busAccess(1'b0, windowAddress(word), 4'hF, '0, fillTimeout, result, waited);
		checkValue(result, backing[int'({region, word})], "SRAM read during fill");
		checkCount++;
		if (waited < 2) begin
			errorCount++;
			$display("Fail at %0t ns: read during fill waited only %0d cycles", $time, waited);
		end
		readCheck(registerAddress(cachePkg::statusOffset), 32'h1, "status after second fill");
		readCheck(registerAddress(cachePkg::cacheStatusOffset), 32'h0000_00FF,
			"cache status after second fill");
		readCheck(registerAddress(cachePkg::pageAddressOffset), {8'h0, region, 11'h0},
			"page address after second fill");
		checkAllWords(region);
		exerciseWindow(100, 1'b1);

		// Steer random addresses clear of both windows
		repeat (50) begin
			addr = 24'($random(seed));
			if (addr[23:12] == cachePkg::registerBase) begin
				addr[22] = 1'b1;
			end
			if (!addr[23] && addr[22:11] == 12'h000) begin
				addr[15] = 1'b1;
			end
			busAccess(1'b0, addr, 4'hF, '0, accessTimeout, result, waited);
			checkValue(result, 32'hFFFF_FFFF, "unmapped address");
			checkValue(32'(waited), 32'd0, "unmapped access wait cycles");
		end

		$display("Checks run: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== hdl/flashCache.sv ====
`timescale 1ns/1ns
`default_nettype none

module flashCache (
	input wire clk,
	input wire rst,

	// Peripheral bus
	input wire we,
	input wire oe,
	input wire [cachePkg::busAddressWidth-1:0] address,
	input wire [3:0] byteSelect,
	input wire [31:0] dataWrite,
	output logic [31:0] dataRead,
	output logic busy,

	// Backing memory
	output logic memEnable,
	output logic [cachePkg::busAddressWidth-1:0] memAddress,
	input wire [31:0] memDataRead,
	input wire memBusy
);

	wire winRequest;
	wire winWrite;
	wire [cachePkg::sramAddressSize-1:0] winAddress;
	wire [3:0] winByteSelect;
	wire [31:0] winDataWrite;
	wire [31:0] winDataRead;
	wire winBusy;

	wire cacheEnable;
	wire manualPageAddressSet;
	wire [cachePkg::manualPageWidth-1:0] manualPageAddress;
	wire cacheBusy;
	wire cacheInitialised;
	wire cacheRequestData;
	wire [cachePkg::pageCount-1:0] pageAddressSet;
	wire [cachePkg::pageCount-1:0] pageRequestLoad;

	wire fillWrite;
	wire [cachePkg::sramAddressSize-1:0] fillAddress;
	wire [31:0] fillData;
	wire fillBusy;

	wire sramEnable;
	wire sramWrite;
	wire [cachePkg::sramAddressSize-1:0] sramAddress;
	wire [3:0] sramByteSelect;
	wire [31:0] sramDataWrite;
	wire [31:0] sramDataRead;

	cacheManagement management (
		.clk(clk),
		.rst(rst),
		.we(we),
		.oe(oe),
		.address(address),
		.byteSelect(byteSelect),
		.dataWrite(dataWrite),
		.dataRead(dataRead),
		.busy(busy),
		.winRequest(winRequest),
		.winWrite(winWrite),
		.winAddress(winAddress),
		.winByteSelect(winByteSelect),
		.winDataWrite(winDataWrite),
		.winDataRead(winDataRead),
		.winBusy(winBusy),
		.cacheEnable(cacheEnable),
		.manualPageAddressSet(manualPageAddressSet),
		.manualPageAddress(manualPageAddress),
		.cacheBusy(cacheBusy),
		.cacheInitialised(cacheInitialised),
		.cacheRequestData(cacheRequestData),
		.pageAddressSet(pageAddressSet),
		.pageRequestLoad(pageRequestLoad)
	);

	pageController controller (
		.clk(clk),
		.rst(rst),
		.cacheEnable(cacheEnable),
		.manualPageAddressSet(manualPageAddressSet),
		.manualPageAddress(manualPageAddress),
		.memEnable(memEnable),
		.memAddress(memAddress),
		.memDataRead(memDataRead),
		.memBusy(memBusy),
		.fillWrite(fillWrite),
		.fillAddress(fillAddress),
		.fillData(fillData),
		.fillBusy(fillBusy),
		.cacheBusy(cacheBusy),
		.cacheInitialised(cacheInitialised),
		.cacheRequestData(cacheRequestData),
		.pageAddressSet(pageAddressSet),
		.pageRequestLoad(pageRequestLoad)
	);

	sramArbiter arbiter (
		.clk(clk),
		.rst(rst),
		.fillWrite(fillWrite),
		.fillAddress(fillAddress),
		.fillData(fillData),
		.fillBusy(fillBusy),
		.winRequest(winRequest),
		.winWrite(winWrite),
		.winAddress(winAddress),
		.winByteSelect(winByteSelect),
		.winDataWrite(winDataWrite),
		.winDataRead(winDataRead),
		.winBusy(winBusy),
		.sramEnable(sramEnable),
		.sramWrite(sramWrite),
		.sramAddress(sramAddress),
		.sramByteSelect(sramByteSelect),
		.sramDataWrite(sramDataWrite),
		.sramDataRead(sramDataRead)
	);

	cacheSram sram (
		.clk(clk),
		.sramEnable(sramEnable),
		.sramWrite(sramWrite),
		.sramAddress(sramAddress),
		.sramByteSelect(sramByteSelect),
		.sramDataWrite(sramDataWrite),
		.sramDataRead(sramDataRead)
	);

endmodule

`default_nettype wire

// ==== hdl/cacheManagement.sv ====
`timescale 1ns/1ns
`default_nettype none

module cacheManagement (
	input wire clk,
	input wire rst,

	// Peripheral bus
	input wire we,
	input wire oe,
	input wire [cachePkg::busAddressWidth-1:0] address,
	input wire [3:0] byteSelect,
	input wire [31:0] dataWrite,
	output logic [31:0] dataRead,
	output logic busy,

	// SRAM window
	output logic winRequest,
	output logic winWrite,
	output logic [cachePkg::sramAddressSize-1:0] winAddress,
	output logic [3:0] winByteSelect,
	output logic [31:0] winDataWrite,
	input wire [31:0] winDataRead,
	input wire winBusy,

	// Page controller
	output logic cacheEnable,
	output logic manualPageAddressSet,
	output logic [cachePkg::manualPageWidth-1:0] manualPageAddress,
	input wire cacheBusy,
	input wire cacheInitialised,
	input wire cacheRequestData,
	input wire [cachePkg::pageCount-1:0] pageAddressSet,
	input wire [cachePkg::pageCount-1:0] pageRequestLoad
);

	localparam int aw = cachePkg::busAddressWidth;
	localparam int lowBits = cachePkg::sramAddressSize + 2;

	logic [cachePkg::configWidth-1:0] configuration;
	logic writeEnable;
	logic registerSelect;
	logic sramWindow;
	logic [11:0] localAddress;
	logic configSelect;
	logic statusSelect;
	logic pageAddressSelect;
	logic cacheStatusSelect;
	logic sramAccess;
	logic fillActive;
	logic pageWrite;

	assign localAddress = address[11:0];
	assign registerSelect = address[aw-1:12] == cachePkg::registerBase;
	assign sramWindow = !address[aw-1] && (address[aw-2:lowBits] == '0);

	assign configSelect = registerSelect && localAddress == cachePkg::configOffset;
	assign statusSelect = registerSelect && localAddress == cachePkg::statusOffset;
	assign pageAddressSelect = registerSelect && localAddress == cachePkg::pageAddressOffset;
	assign cacheStatusSelect = registerSelect && localAddress == cachePkg::cacheStatusOffset;

	assign cacheEnable = configuration[0];
	assign writeEnable = configuration[2];

	// Covers the cycle between the start pulse and cacheBusy rising
	assign fillActive = cacheBusy || manualPageAddressSet;
	assign pageWrite = we && pageAddressSelect;

	always_ff @(posedge clk) begin
		if (rst) begin
			configuration <= '0;
			manualPageAddress <= '0;
			manualPageAddressSet <= 1'b0;
		end else begin
			if (we && configSelect && byteSelect[0]) begin
				configuration <= dataWrite[cachePkg::configWidth-1:0];
			end
			manualPageAddressSet <= pageWrite && !fillActive;
			if (pageWrite && !fillActive) begin
				manualPageAddress <= dataWrite[aw-1 -: cachePkg::manualPageWidth];
			end
		end
	end

	// Window writes with writeEnable clear are dropped
	assign sramAccess = sramWindow && (oe || (we && writeEnable));
	assign winRequest = sramAccess && !fillActive;
	assign winWrite = we && !oe;
	assign winAddress = address[lowBits-1:2];
	assign winByteSelect = byteSelect;
	assign winDataWrite = dataWrite;

	always_comb begin
		if (sramWindow) begin
			busy = sramAccess && (fillActive || winBusy);
		end else begin
			busy = pageWrite && fillActive;
		end
	end

	always_comb begin
		if (configSelect) begin
			dataRead = 32'(configuration);
		end else if (statusSelect) begin
			dataRead = 32'({cacheRequestData, cacheInitialised});
		end else if (pageAddressSelect) begin
			// Region number read back as a byte address
			dataRead = 32'({manualPageAddress, {lowBits{1'b0}}});
		end else if (cacheStatusSelect) begin
			dataRead = 32'({pageRequestLoad, pageAddressSet});
		end else if (sramWindow) begin
			dataRead = winDataRead;
		end else begin
			dataRead = '1;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/pageController.sv ====
`timescale 1ns/1ns
`default_nettype none

module pageController (
	input wire clk,
	input wire rst,
	input wire cacheEnable,
	input wire manualPageAddressSet,
	input wire [cachePkg::manualPageWidth-1:0] manualPageAddress,

	// Backing memory
	output logic memEnable,
	output logic [cachePkg::busAddressWidth-1:0] memAddress,
	input wire [31:0] memDataRead,
	input wire memBusy,

	// SRAM fill port
	output logic fillWrite,
	output logic [cachePkg::sramAddressSize-1:0] fillAddress,
	output logic [31:0] fillData,
	input wire fillBusy,

	// Status
	output logic cacheBusy,
	output logic cacheInitialised,
	output logic cacheRequestData,
	output logic [cachePkg::pageCount-1:0] pageAddressSet,
	output logic [cachePkg::pageCount-1:0] pageRequestLoad
);

	typedef enum logic [1:0] {
		idleState,
		fetchState,
		storeState
	} fillState;

	fillState state;
	logic [cachePkg::sramAddressSize-1:0] wordCounter;
	logic [cachePkg::manualPageWidth-1:0] region;
	logic [31:0] memData;
	logic [cachePkg::pageIndexSize-1:0] pageIndex;
	logic pageEnd;
	logic lastWord;

	assign pageIndex = wordCounter[cachePkg::sramAddressSize-1 -: cachePkg::pageIndexSize];
	assign pageEnd = &wordCounter[cachePkg::pageWordSize-1:0];
	assign lastWord = &wordCounter;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= idleState;
			wordCounter <= '0;
			cacheInitialised <= 1'b0;
			pageAddressSet <= '0;
			pageRequestLoad <= '0;
		end else begin
			case (state)
				idleState: begin
					// A request with the cache disabled is dropped
					if (manualPageAddressSet && cacheEnable) begin
						wordCounter <= '0;
						pageRequestLoad <= '1;
						pageAddressSet <= '0;
						state <= fetchState;
					end
				end
				fetchState: begin
					if (!memBusy) begin
						state <= storeState;
					end
				end
				storeState: begin
					if (!fillBusy) begin
						if (pageEnd) begin
							pageRequestLoad[pageIndex] <= 1'b0;
							pageAddressSet[pageIndex] <= 1'b1;
						end
						if (lastWord) begin
							cacheInitialised <= 1'b1;
							state <= idleState;
						end else begin
							wordCounter <= wordCounter + 1'b1;
							state <= fetchState;
						end
					end
				end
				default: state <= idleState;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == idleState && manualPageAddressSet) begin
			region <= manualPageAddress;
		end
		if (state == fetchState && !memBusy) begin
			memData <= memDataRead;
		end
	end

	assign memEnable = state == fetchState;
	assign memAddress = {region, wordCounter, 2'b00};

	assign fillWrite = state == storeState;
	assign fillAddress = wordCounter;
	assign fillData = memData;

	assign cacheBusy = state != idleState;
	assign cacheRequestData = |pageRequestLoad;

endmodule

`default_nettype wire

// ==== hdl/sramArbiter.sv ====
`timescale 1ns/1ns
`default_nettype none

module sramArbiter (
	input wire clk,
	input wire rst,

	// Fill port
	input wire fillWrite,
	input wire [cachePkg::sramAddressSize-1:0] fillAddress,
	input wire [31:0] fillData,
	output logic fillBusy,

	// Bus window port
	input wire winRequest,
	input wire winWrite,
	input wire [cachePkg::sramAddressSize-1:0] winAddress,
	input wire [3:0] winByteSelect,
	input wire [31:0] winDataWrite,
	output logic [31:0] winDataRead,
	output logic winBusy,

	// SRAM port
	output logic sramEnable,
	output logic sramWrite,
	output logic [cachePkg::sramAddressSize-1:0] sramAddress,
	output logic [3:0] sramByteSelect,
	output logic [31:0] sramDataWrite,
	input wire [31:0] sramDataRead
);

	logic readPending;
	logic fillGrant;
	logic winGrant;

	// Window read data comes back the cycle after the grant
	always_ff @(posedge clk) begin
		if (rst) begin
			readPending <= 1'b0;
		end else begin
			readPending <= winGrant && !winWrite;
		end
	end

	// Fill waits out the read return cycle only
	assign fillBusy = readPending;
	assign fillGrant = fillWrite && !readPending;
	assign winGrant = winRequest && !fillWrite && !readPending;

	assign sramEnable = fillGrant || winGrant;
	assign sramWrite = fillGrant || (winGrant && winWrite);
	assign sramAddress = fillGrant ? fillAddress : winAddress;
	assign sramByteSelect = fillGrant ? 4'hF : winByteSelect;
	assign sramDataWrite = fillGrant ? fillData : winDataWrite;

	assign winDataRead = sramDataRead;
	assign winBusy = winRequest && !readPending && !(winGrant && winWrite);

endmodule

`default_nettype wire

// ==== hdl/cacheSram.sv ====
`timescale 1ns/1ns
`default_nettype none

module cacheSram (
	input wire clk,
	input wire sramEnable,
	input wire sramWrite,
	input wire [cachePkg::sramAddressSize-1:0] sramAddress,
	input wire [3:0] sramByteSelect,
	input wire [31:0] sramDataWrite,
	output logic [31:0] sramDataRead
);

	localparam int depth = 1 << cachePkg::sramAddressSize;

	logic [31:0] memory [0:depth-1];

	// Writes leave the read register alone so an earlier read result stays put
	always_ff @(posedge clk) begin
		if (sramEnable) begin
			if (sramWrite) begin
				for (int lane = 0; lane < 4; lane++) begin
					if (sramByteSelect[lane]) begin
						memory[sramAddress][lane*8 +: 8] <= sramDataWrite[lane*8 +: 8];
					end
				end
			end else begin
				sramDataRead <= memory[sramAddress];
			end
		end
	end

endmodule

`default_nettype wire

// ==== hdl/cachePkg.sv ====
`default_nettype none

package cachePkg;

	// SRAM geometry
	localparam int sramAddressSize = 9;
	localparam int pageIndexSize = 3;
	localparam int pageCount = 1 << pageIndexSize;
	localparam int pageWordSize = sramAddressSize - pageIndexSize;

	// Peripheral bus and backing memory use the same byte address width
	localparam int busAddressWidth = 24;

	// Region number that selects one SRAM-sized block of backing memory
	localparam int manualPageWidth = busAddressWidth - sramAddressSize - 2;

	// Register window decode
	localparam logic [11:0] registerBase = 12'h800;

	localparam logic [11:0] configOffset = 12'h000;
	localparam logic [11:0] statusOffset = 12'h004;
	localparam logic [11:0] pageAddressOffset = 12'h008;
	localparam logic [11:0] cacheStatusOffset = 12'h00C;

	// Configuration bits
	// 0 enable, 1 automaticPaging (stored only), 2 writeEnable
	localparam int configWidth = 3;

endpackage

`default_nettype wire
